//--- dv/pcie_ep_tb.sv
// Testbench for the PCIe endpoint target
// Drives MWr32/MRd32 TLPs on the receive Local-Link, keeps a register
// model and a ring of expected CplD beats, and checks the DUT ports
// with concurrent assertions. Back-pressure and interrupt ready are random
`timescale 1ns/100ps
`include "pcie_ep_defs.svh"

module pcie_ep_tb;
  import pcie_ep_pkg::*;

  localparam int NUM_TRANS = 53;              // Writes and reads in the sequence
  localparam int LIMIT     = NUM_TRANS * 40;  // Cycle budget

  logic        clk = 1'b0;
  logic        rst_i;
  logic [63:0] trn_rd;
  logic        rsof_n, reof_n, rsrc_rdy_n, to_turnoff_n;
  logic        tdst_rdy_n = 1'b0;             // Random once running
  logic        irq_rdy_n  = 1'b1;
  logic [6:0]  rbar_hit_n;
  logic [15:0] cfg_command;
  logic        msi_en;
  logic        rdst_rdy_n, tsof_n, teof_n, tsrc_rdy_n, turnoff_ok_n;
  logic        irq_n, irq_assert_n;
  logic [63:0] td;
  logic [7:0]  irq_di;

  logic [31:0] seed = 32'hb10fdb33;
  int          errors = 0;
  int          cycles = 0;
  logic [31:0] model [0:15];                  // Register model
  logic [63:0] exp_b1 [0:127];                // Expected CplD beats
  logic [63:0] exp_b2 [0:127];
  logic [6:0]  exp_head = '0, exp_tail = '0;
  logic [63:0] exp_b1_cur, exp_b2_cur;
  logic        taken;
  logic        prev_held, prev_sof, prev_eof, prev_irq_wait;
  logic [63:0] prev_td;
  logic        exp_assert_n = 1'b0;           // Kind of legacy message due
  int          irq_count = 0;
  logic [31:0] r;

  always #4 clk = ~clk;                       // 8 ns period

  pcie_ep_top pcie_ep_top_i (
    .trn_clk_i(clk), .rst_i(rst_i), .trn_lnk_up_n_i(1'b0),
    .trn_rd_i(trn_rd), .trn_rsof_n_i(rsof_n), .trn_reof_n_i(reof_n),
    .trn_rsrc_rdy_n_i(rsrc_rdy_n), .trn_rbar_hit_n_i(rbar_hit_n), .trn_rdst_rdy_n_o(rdst_rdy_n),
    .trn_td_o(td), .trn_tsof_n_o(tsof_n), .trn_teof_n_o(teof_n),
    .trn_tsrc_rdy_n_o(tsrc_rdy_n), .trn_tdst_rdy_n_i(tdst_rdy_n),
    .cfg_bus_number_i(8'h3a), .cfg_device_number_i(5'h11), .cfg_function_number_i(3'h5),
    .cfg_command_i(cfg_command), .cfg_to_turnoff_n_i(to_turnoff_n),
    .cfg_turnoff_ok_n_o(turnoff_ok_n), .cfg_interrupt_n_o(irq_n),
    .cfg_interrupt_rdy_n_i(irq_rdy_n), .cfg_interrupt_assert_n_o(irq_assert_n),
    .cfg_interrupt_di_o(irq_di), .cfg_interrupt_msienable_i(msi_en)
  );

  assign taken      = !tsrc_rdy_n && !tdst_rdy_n;
  assign exp_b1_cur = exp_b1[exp_head];
  assign exp_b2_cur = exp_b2[exp_head];

  // ------------------------------
  // Random responders and monitors
  // ------------------------------
  always @(posedge clk) begin
    tdst_rdy_n <= $random(seed) % 2 != 0;     // Tx back-pressure
    irq_rdy_n  <= $random(seed) % 2 != 0;     // Interrupt grant
  end

  always @(posedge clk) begin
    prev_held     <= !rst_i && !tsrc_rdy_n && tdst_rdy_n;
    prev_td       <= td;
    prev_sof      <= tsof_n;
    prev_eof      <= teof_n;
    prev_irq_wait <= !rst_i && !irq_n && irq_rdy_n;
    if (!rst_i && taken && !teof_n && exp_head != exp_tail)
      exp_head <= exp_head + 7'd1;            // CplD consumed
    if (!rst_i && !irq_n && !irq_rdy_n)
      irq_count <= irq_count + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Errors: %0d", errors + 1);
      $display("Done: errors found");
      $finish;
    end
  end

  // ------------------------------
  // Port checks
  // ------------------------------
  a_cpl_hdr: assert property (@(posedge clk) disable iff (rst_i)
    (taken && !tsof_n) |-> td == exp_b1_cur)
    else begin
      errors++;
      $display("CHECK FAILED trn_td_o hdr got %h exp %h", $sampled(td), $sampled(exp_b1_cur));
    end
  a_cpl_data: assert property (@(posedge clk) disable iff (rst_i)
    (taken && !teof_n) |-> td == exp_b2_cur)
    else begin
      errors++;
      $display("CHECK FAILED trn_td_o data got %h exp %h", $sampled(td), $sampled(exp_b2_cur));
    end
  a_cpl_frame: assert property (@(posedge clk) disable iff (rst_i)
    taken |-> tsof_n != teof_n)               // Each beat is either sof or eof
    else begin
      errors++;
      $display("CHECK FAILED trn_tsof_n_o %h trn_teof_n_o %h exp one low",
               $sampled(tsof_n), $sampled(teof_n));
    end
  a_cpl_wanted: assert property (@(posedge clk) disable iff (rst_i)
    (taken && !teof_n) |-> exp_head != exp_tail)
    else begin
      errors++;
      $display("A completion was sent with no read outstanding");
    end
  a_beat_hold: assert property (@(posedge clk) disable iff (rst_i)
    prev_held |-> (!tsrc_rdy_n && td == prev_td && tsof_n == prev_sof && teof_n == prev_eof))
    else begin
      errors++;
      $display("CHECK FAILED trn_td_o got %h exp %h", $sampled(td), $sampled(prev_td));
    end
  a_rx_held: assert property (@(posedge clk) disable iff (rst_i)
    !tsrc_rdy_n |-> rdst_rdy_n)
    else begin
      errors++;
      $display("CHECK FAILED trn_rdst_rdy_n_o got %h exp 1", $sampled(rdst_rdy_n));
    end
  a_turnoff: assert property (@(posedge clk) disable iff (rst_i)
    !turnoff_ok_n |-> tsrc_rdy_n)
    else begin
      errors++;
      $display("CHECK FAILED cfg_turnoff_ok_n_o got 0 exp 1");
    end
  a_intx_kind: assert property (@(posedge clk) disable iff (rst_i)
    (!msi_en && !irq_n) |-> irq_assert_n == exp_assert_n)
    else begin
      errors++;
      $display("CHECK FAILED cfg_interrupt_assert_n_o got %h exp %h",
               $sampled(irq_assert_n), $sampled(exp_assert_n));
    end
  a_intx_off: assert property (@(posedge clk) disable iff (rst_i)
    (cfg_command[10] && !msi_en) |-> irq_n)
    else begin
      errors++;
      $display("CHECK FAILED cfg_interrupt_n_o got 0 exp 1");
    end
  a_irq_hold: assert property (@(posedge clk) disable iff (rst_i)
    prev_irq_wait |-> !irq_n)
    else begin
      errors++;
      $display("CHECK FAILED cfg_interrupt_n_o got 1 exp 0");
    end
  a_irq_di: assert property (@(posedge clk) disable iff (rst_i)
    !irq_n |-> irq_di == 8'h00)
    else begin
      errors++;
      $display("CHECK FAILED cfg_interrupt_di_o got %h exp 00", $sampled(irq_di));
    end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  // Two beats, each held until the DUT takes it
  task automatic send_tlp(input logic [31:0] d0, d1, d2, d3, input logic hit);
    @(posedge clk);
    trn_rd     <= {d0, d1};
    rsof_n     <= 1'b0;
    reof_n     <= 1'b1;
    rsrc_rdy_n <= 1'b0;
    rbar_hit_n <= hit ? 7'h7e : 7'h7f;
    @(posedge clk);
    while (rdst_rdy_n) @(posedge clk);
    trn_rd <= {d2, d3};
    rsof_n <= 1'b1;
    reof_n <= 1'b0;
    @(posedge clk);
    while (rdst_rdy_n) @(posedge clk);
    rsrc_rdy_n <= 1'b1;
    reof_n     <= 1'b1;
  endtask

  function automatic logic [31:0] dw0(input logic [6:0] ft, input logic [2:0] tc,
                                      input logic [1:0] attr, input logic [9:0] len);
    return {1'b0, ft, 1'b0, tc, 4'b0000, 2'b00, attr, 2'b00, len};
  endfunction

  // Model follows only writes that the endpoint accepts
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] be, input logic hit,
                           input logic [6:0] ft, input logic [9:0] len);
    send_tlp(dw0(ft, 3'd0, 2'd0, len), {16'h0100, 8'h00, 4'h0, be},
             {26'h0, addr, 2'b00}, data, hit);
    if (hit && ft == TLP_MWR32 && len == 10'd1) begin
      if (addr == 4'd1 && be[0]) begin
        if (data[0])
          model[1] = 32'd1;                   // Set wins
        else if (data[1])
          model[1] = 32'd0;
      end else if (addr > 4'd1) begin
        for (int b = 0; b < 4; b++)
          if (be[b])
            model[addr][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic read_reg(input logic [3:0] addr);
    logic [31:0] rnd;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [2:0]  tc;
    logic [1:0]  attr;
    rnd  = $random(seed);
    tc   = rnd[2:0];
    attr = rnd[4:3];
    d1   = {rnd[31:8], 4'h0, 4'hf};           // Rid and tag random
    d2   = {rnd[31:6], addr, 2'b00};          // Address bit 6 random too
    exp_b1[exp_tail] = {dw0(TLP_CPLD, tc, attr, 10'd1), 8'h3a, 5'h11, 3'h5, 4'h0, 12'd4};
    exp_b2[exp_tail] = {d1[31:8], 1'b0, d2[6:0], model[addr]};
    exp_tail = exp_tail + 7'd1;
    send_tlp(dw0(TLP_MRD32, tc, attr, 10'd1), d1, d2, 32'h0, 1'b1);
  endtask

  task automatic wait_irq(input int n);
    while (irq_count < n) @(posedge clk);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    rst_i <= 1'b1;
    trn_rd <= '0;
    rsof_n <= 1'b1;
    reof_n <= 1'b1;
    rsrc_rdy_n <= 1'b1;
    rbar_hit_n <= 7'h7f;
    to_turnoff_n <= 1'b1;
    cfg_command <= 16'h0000;
    msi_en <= 1'b0;
    model[0] = `PCIE_EP_VERSION;
    for (int i = 1; i < 16; i++)
      model[i] = 32'h0;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;

    for (int i = 0; i < 12; i++) begin       // Random write then read back
      r = $random(seed);
      write_reg(4'd2 + {1'b0, r[2:0]} + {3'b0, r[3]} * 4'd6, $random(seed), r[7:4], 1'b1,
                TLP_MWR32, 10'd1);
      read_reg(4'd2 + {1'b0, r[2:0]} + {3'b0, r[3]} * 4'd6);
    end
    read_reg(4'd0);                           // Version, before and after a write
    write_reg(4'd0, 32'hdead_beef, 4'hf, 1'b1, TLP_MWR32, 10'd1);
    read_reg(4'd0);
    write_reg(4'd5, 32'h1111_1111, 4'hf, 1'b0, TLP_MWR32, 10'd1);  // BAR miss
    write_reg(4'd6, 32'h2222_2222, 4'hf, 1'b1, 7'b11_00000, 10'd1); // 4DW type
    write_reg(4'd7, 32'h3333_3333, 4'hf, 1'b1, TLP_MWR32, 10'd2);   // Length 2
    read_reg(4'd5);
    read_reg(4'd6);
    read_reg(4'd7);
    for (int i = 0; i < 8; i++)               // Back-to-back reads
      read_reg(4'd2 + 4'(i));

    exp_assert_n = 1'b0;                      // Legacy assert and deassert
    write_reg(4'd1, 32'h1, 4'h1, 1'b1, TLP_MWR32, 10'd1);
    wait_irq(1);
    read_reg(4'd1);
    exp_assert_n = 1'b1;
    write_reg(4'd1, 32'h2, 4'h1, 1'b1, TLP_MWR32, 10'd1);
    wait_irq(2);
    read_reg(4'd1);
    @(posedge clk);
    cfg_command <= 16'h0400;                  // Interrupt Disable
    write_reg(4'd1, 32'h1, 4'h1, 1'b1, TLP_MWR32, 10'd1);
    read_reg(4'd1);
    write_reg(4'd1, 32'h2, 4'h1, 1'b1, TLP_MWR32, 10'd1);
    repeat (10) @(posedge clk);
    cfg_command <= 16'h0000;
    msi_en      <= 1'b1;
    write_reg(4'd1, 32'h1, 4'h1, 1'b1, TLP_MWR32, 10'd1);
    wait_irq(3);
    read_reg(4'd1);                           // Pending bit
    write_reg(4'd1, 32'h2, 4'h1, 1'b1, TLP_MWR32, 10'd1);
    read_reg(4'd1);

    while (exp_head != exp_tail) @(posedge clk);
    read_reg(4'd3);                           // Turn-off behind a pending read
    to_turnoff_n <= 1'b0;
    @(posedge clk);
    while (turnoff_ok_n) @(posedge clk);
    to_turnoff_n <= 1'b1;
    repeat (5) @(posedge clk);

    if (exp_head != exp_tail) begin
      errors++;
      $display("Reads left without a completion");
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- hdl/pcie_ep_ctrl.sv
// Endpoint control
// Forms the endpoint reset, starts one CplD per read request and holds
// the receive Local-Link until that CplD is sent. Turn-off is granted
// only while no completion is pending
`timescale 1ns/100ps

module pcie_ep_ctrl (
  input  logic trn_clk_i,
  input  logic rst_i,
  input  logic trn_lnk_up_n_i,
  input  logic rd_req_i,            // Read decoded by rx engine
  input  logic cpl_done_i,          // CplD eof taken
  input  logic cfg_to_turnoff_n_i,
  output logic ep_rst_o,
  output logic rx_hold_o,
  output logic cpl_start_o,
  output logic cfg_turnoff_ok_n_o
);
  import pcie_ep_pkg::*;

  ctrl_state_e state;

  assign ep_rst_o  = rst_i | trn_lnk_up_n_i;          // Link down resets all
  assign rx_hold_o = (state != CTRL_IDLE) | rd_req_i; // Hold from the request on

  // A read still in flight when turn-off came in cancels the grant
  assign cfg_turnoff_ok_n_o = (state != CTRL_TURNOFF) | rd_req_i;

  always_ff @(posedge trn_clk_i) begin
    if (ep_rst_o) begin
      state       <= CTRL_IDLE;
      cpl_start_o <= 1'b0;
    end else begin
      cpl_start_o <= 1'b0;
      case (state)
        CTRL_IDLE, CTRL_TURNOFF: begin
          if (rd_req_i) begin
            state       <= CTRL_CPL_WAIT;
            cpl_start_o <= 1'b1;                      // Tx builds the CplD
          end else if (!cfg_to_turnoff_n_i) begin
            state <= CTRL_TURNOFF;                    // Nothing pending
          end else begin
            state <= CTRL_IDLE;                       // Request withdrawn
          end
        end
        CTRL_CPL_WAIT: begin
          if (cpl_done_i)
            state <= CTRL_IDLE;
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

  // Rx hold keeps reads from overlapping a pending completion
  a_no_rd_req_in_wait: assert property (@(posedge trn_clk_i) disable iff (ep_rst_o)
    (state == CTRL_CPL_WAIT) |-> !rd_req_i)
    else $error("rd_req while a completion is pending");

endmodule

//--- hdl/pcie_ep_defs.svh
// Constants shared by the PCIe endpoint target RTL
// Include in any file that needs bus widths or the register map
`ifndef PCIE_EP_DEFS_SVH
`define PCIE_EP_DEFS_SVH

// ------------------------------
// Widths
// ------------------------------
`define PCIE_EP_DATA_W    64            // Local-Link data bus
`define PCIE_EP_REG_W     32            // One register is one DW
`define PCIE_EP_REG_NUM   16
`define PCIE_EP_REG_AW    4             // DW address bits 5:2

// ------------------------------
// Register map
// ------------------------------
`define PCIE_EP_BAR       0             // Served bit of trn_rbar_hit_n
`define PCIE_EP_VERSION   32'h0001_0200 // Read-only reg 0
`define PCIE_EP_REG_IRQ   1             // Interrupt control word

// Byte count of every CplD since reads are one full DW
`define PCIE_EP_CPL_BYTES 12'd4

`endif

//--- hdl/pcie_ep_intr_ctrl.sv
// Interrupt request sequencer
// Legacy mode sends INTx assert and deassert messages that follow the
// pending bit, gated by Interrupt Disable. MSI mode sends one request
// per set. Each request is held until cfg_interrupt_rdy_n is seen low
`timescale 1ns/100ps

module pcie_ep_intr_ctrl (
  input  logic        trn_clk_i,
  input  logic        ep_rst_i,
  input  logic        irq_set_i,
  input  logic        irq_clr_i,
  input  logic        cfg_interrupt_rdy_n_i,
  input  logic        cfg_interrupt_msienable_i,
  input  logic [15:0] cfg_command_i,
  output logic        irq_status_o,
  output logic        cfg_interrupt_n_o,
  output logic        cfg_interrupt_assert_n_o,
  output logic [7:0]  cfg_interrupt_di_o
);
  import pcie_ep_pkg::*;

  intr_state_e state;
  logic        intx_on;    // Assert message sent and not yet undone
  logic        intx_want;  // INTx line should be high
  logic        msi_pend;   // Set not yet sent as MSI

  assign intx_want = irq_status_o && !cfg_command_i[10]; // Interrupt Disable

  assign cfg_interrupt_n_o        = (state == IRQ_IDLE);
  assign cfg_interrupt_assert_n_o = (state != IRQ_ASSERT) || cfg_interrupt_msienable_i;
  assign cfg_interrupt_di_o       = 8'h00; // INTA and MSI vector 0

  always_ff @(posedge trn_clk_i) begin
    if (ep_rst_i) begin
      state        <= IRQ_IDLE;
      irq_status_o <= 1'b0;
      intx_on      <= 1'b0;
      msi_pend     <= 1'b0;
    end else begin
      if (irq_set_i)
        irq_status_o <= 1'b1;
      else if (irq_clr_i)
        irq_status_o <= 1'b0;
      case (state)
        IRQ_IDLE: begin
          if (cfg_interrupt_msienable_i) begin
            if (msi_pend) begin
              state    <= IRQ_ASSERT;
              msi_pend <= 1'b0;
            end
          end else if (intx_want && !intx_on) begin
            state <= IRQ_ASSERT;
          end else if (!intx_want && intx_on) begin
            state <= IRQ_DEASSERT;
          end
        end
        IRQ_ASSERT: begin
          if (!cfg_interrupt_rdy_n_i) begin
            state <= IRQ_IDLE;
            if (!cfg_interrupt_msienable_i)
              intx_on <= 1'b1;
          end
        end
        IRQ_DEASSERT: begin
          if (!cfg_interrupt_rdy_n_i) begin
            state   <= IRQ_IDLE;
            intx_on <= 1'b0;
          end
        end
        default: state <= IRQ_IDLE;
      endcase
      if (irq_set_i && cfg_interrupt_msienable_i)
        msi_pend <= 1'b1;                  // New set wins over the clear
    end
  end

endmodule

//--- hdl/pcie_ep_pkg.sv
// Types for the PCIe endpoint target
// TLP encodings and the state enums of the FSMs
package pcie_ep_pkg;

  // Fmt[1:0] and Type[4:0] of header DW0
  typedef enum logic [6:0] {
    TLP_MRD32 = 7'b00_00000, // 3DW header without data
    TLP_MWR32 = 7'b10_00000, // 3DW header with data
    TLP_CPLD  = 7'b10_01010  // Completion with data
  } tlp_fmt_type_e;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_CPL_WAIT,           // Completion pending
    CTRL_TURNOFF             // Turn-off granted
  } ctrl_state_e;

  typedef enum logic [1:0] {
    RX_HDR,                  // Waiting for sof beat
    RX_DATA,                 // DW2 and payload beat
    RX_DROP                  // Skip to eof
  } rx_state_e;

  typedef enum logic [1:0] {TX_IDLE, TX_HDR, TX_DATA} tx_state_e;

  typedef enum logic [1:0] {IRQ_IDLE, IRQ_ASSERT, IRQ_DEASSERT} intr_state_e;

endpackage

//--- hdl/pcie_ep_regs.sv
// Target register file on BAR 0
// Reg 0 is the version word and reg 1 the interrupt control word.
// Regs 2 to 15 are scratch DWs written per byte. Read data is
// combinational from the register address
`timescale 1ns/100ps
`include "pcie_ep_defs.svh"

module pcie_ep_regs (
  input  logic                       trn_clk_i,
  input  logic                       ep_rst_i,
  input  logic                       reg_wr_i,
  input  logic [`PCIE_EP_REG_AW-1:0] reg_addr_i,
  input  logic [`PCIE_EP_REG_W-1:0]  reg_wdata_i,
  input  logic [3:0]                 reg_be_i,
  input  logic                       irq_status_i,  // Pending interrupt
  output logic [`PCIE_EP_REG_W-1:0]  reg_rdata_o,
  output logic                       irq_set_o,
  output logic                       irq_clr_o
);

  logic [`PCIE_EP_REG_W-1:0] scratch [`PCIE_EP_REG_NUM-1:2];
  logic                      irq_wr;   // Low byte of reg 1 written

  assign irq_wr = reg_wr_i && reg_addr_i == `PCIE_EP_REG_IRQ && reg_be_i[0];

  always_ff @(posedge trn_clk_i) begin
    if (ep_rst_i) begin
      for (int i = 2; i < `PCIE_EP_REG_NUM; i++)
        scratch[i] <= '0;
      irq_set_o <= 1'b0;
      irq_clr_o <= 1'b0;
    end else begin
      irq_set_o <= irq_wr && reg_wdata_i[0];
      irq_clr_o <= irq_wr && reg_wdata_i[1];
      if (reg_wr_i && reg_addr_i > `PCIE_EP_REG_IRQ) begin // Reg 0 is read-only
        for (int b = 0; b < 4; b++)
          if (reg_be_i[b])
            scratch[reg_addr_i][8*b +: 8] <= reg_wdata_i[8*b +: 8];
      end
    end
  end

  // Read mux
  always_comb begin
    case (reg_addr_i)
      4'd0:             reg_rdata_o = `PCIE_EP_VERSION;
      `PCIE_EP_REG_IRQ: reg_rdata_o = {{(`PCIE_EP_REG_W-1){1'b0}}, irq_status_i};
      default:          reg_rdata_o = scratch[reg_addr_i];
    endcase
  end

endmodule

//--- hdl/pcie_ep_rx_engine.sv
// Receive Local-Link decoder
// Takes 3DW MWr32 and MRd32 TLPs of one DW that hit the served BAR.
// Writes become a register write strobe, reads a rd_req strobe with the
// request fields held until the next read. Other packets are dropped
`timescale 1ns/100ps
`include "pcie_ep_defs.svh"

module pcie_ep_rx_engine (
  input  logic                       trn_clk_i,
  input  logic                       ep_rst_i,
  input  logic                       rx_hold_i,
  input  logic [`PCIE_EP_DATA_W-1:0] trn_rd_i,
  input  logic                       trn_rsof_n_i,
  input  logic                       trn_reof_n_i,
  input  logic                       trn_rsrc_rdy_n_i,
  input  logic [6:0]                 trn_rbar_hit_n_i,
  output logic                       reg_wr_o,
  output logic [`PCIE_EP_REG_AW-1:0] reg_addr_o,
  output logic [`PCIE_EP_REG_W-1:0]  reg_wdata_o,
  output logic [3:0]                 reg_be_o,      // First DW byte enables
  output logic                       rd_req_o,
  output logic [15:0]                req_rid_o,
  output logic [7:0]                 req_tag_o,
  output logic [2:0]                 req_tc_o,
  output logic [1:0]                 req_attr_o,
  output logic [6:0]                 req_laddr_o
);
  import pcie_ep_pkg::*;

  rx_state_e                state;
  logic                     beat;      // Beat taken this cycle
  logic [`PCIE_EP_REG_W-1:0] dw_hi;    // DW0 or DW2
  logic [`PCIE_EP_REG_W-1:0] dw_lo;    // DW1 or payload
  logic                     hdr_ok;
  logic                     is_wr;

  assign beat  = !trn_rsrc_rdy_n_i && !rx_hold_i;
  assign dw_hi = trn_rd_i[`PCIE_EP_DATA_W-1:`PCIE_EP_REG_W];
  assign dw_lo = trn_rd_i[`PCIE_EP_REG_W-1:0];

  // Fmt/type, length 1 and BAR hit
  assign hdr_ok = (dw_hi[30:24] == TLP_MWR32 || dw_hi[30:24] == TLP_MRD32) &&
                  dw_hi[9:0] == 10'd1 && !trn_rbar_hit_n_i[`PCIE_EP_BAR];

  always_ff @(posedge trn_clk_i) begin
    if (ep_rst_i) begin
      state    <= RX_HDR;
      reg_wr_o <= 1'b0;
      rd_req_o <= 1'b0;
    end else begin
      reg_wr_o <= 1'b0;
      rd_req_o <= 1'b0;
      if (beat) begin
        case (state)
          RX_HDR: begin
            if (!trn_rsof_n_i && trn_reof_n_i)
              state <= hdr_ok ? RX_DATA : RX_DROP;
          end
          RX_DATA: begin
            state    <= trn_reof_n_i ? RX_DROP : RX_HDR; // Longer than 2 beats
            reg_wr_o <= is_wr && !trn_reof_n_i;
            rd_req_o <= !is_wr && !trn_reof_n_i;
          end
          RX_DROP: begin
            if (!trn_reof_n_i)
              state <= RX_HDR;
          end
          default: state <= RX_HDR;
        endcase
      end
    end
  end

  // Header and payload capture
  always_ff @(posedge trn_clk_i) begin
    if (beat && state == RX_HDR && hdr_ok) begin
      is_wr    <= dw_hi[30];             // Fmt bit for data
      reg_be_o <= dw_lo[3:0];
      if (!dw_hi[30]) begin
        req_tc_o   <= dw_hi[22:20];
        req_attr_o <= dw_hi[13:12];
        req_rid_o  <= dw_lo[31:16];
        req_tag_o  <= dw_lo[15:8];
      end
    end
    if (beat && state == RX_DATA) begin
      reg_addr_o  <= dw_hi[5:2];
      reg_wdata_o <= dw_lo;
      if (!is_wr)
        req_laddr_o <= dw_hi[6:0];
    end
  end

  // A packet in progress is never restarted by the core
  a_no_sof_in_data: assert property (@(posedge trn_clk_i) disable iff (ep_rst_i)
    (state == RX_DATA && beat) |-> trn_rsof_n_i)
    else $error("sof during RX_DATA");

endmodule

//--- hdl/pcie_ep_top.sv
// PCIe endpoint target top level
// Connects the control, receive, register, transmit and interrupt blocks
// between the core's Local-Link and configuration ports
`timescale 1ns/100ps
`include "pcie_ep_defs.svh"

module pcie_ep_top (
  input  logic                       trn_clk_i,
  input  logic                       rst_i,
  input  logic                       trn_lnk_up_n_i,
  // Receive Local-Link
  input  logic [`PCIE_EP_DATA_W-1:0] trn_rd_i,
  input  logic                       trn_rsof_n_i,
  input  logic                       trn_reof_n_i,
  input  logic                       trn_rsrc_rdy_n_i,
  input  logic [6:0]                 trn_rbar_hit_n_i,
  output logic                       trn_rdst_rdy_n_o,
  // Transmit Local-Link
  output logic [`PCIE_EP_DATA_W-1:0] trn_td_o,
  output logic                       trn_tsof_n_o,
  output logic                       trn_teof_n_o,
  output logic                       trn_tsrc_rdy_n_o,
  input  logic                       trn_tdst_rdy_n_i,
  // Configuration
  input  logic [7:0]                 cfg_bus_number_i,
  input  logic [4:0]                 cfg_device_number_i,
  input  logic [2:0]                 cfg_function_number_i,
  input  logic [15:0]                cfg_command_i,
  input  logic                       cfg_to_turnoff_n_i,
  output logic                       cfg_turnoff_ok_n_o,
  output logic                       cfg_interrupt_n_o,
  input  logic                       cfg_interrupt_rdy_n_i,
  output logic                       cfg_interrupt_assert_n_o,
  output logic [7:0]                 cfg_interrupt_di_o,
  input  logic                       cfg_interrupt_msienable_i
);

  logic                       ep_rst;
  logic                       rd_req;
  logic                       cpl_start;
  logic                       cpl_done;
  logic                       reg_wr;
  logic [`PCIE_EP_REG_AW-1:0] reg_addr;
  logic [`PCIE_EP_REG_W-1:0]  reg_wdata;
  logic [`PCIE_EP_REG_W-1:0]  reg_rdata;
  logic [3:0]                 reg_be;
  logic [15:0]                req_rid;
  logic [7:0]                 req_tag;
  logic [2:0]                 req_tc;
  logic [1:0]                 req_attr;
  logic [6:0]                 req_laddr;
  logic                       irq_set;
  logic                       irq_clr;
  logic                       irq_status;

  // ------------------------------
  // Control and receive
  // ------------------------------
  pcie_ep_ctrl u_ctrl (
    .trn_clk_i(trn_clk_i), .rst_i(rst_i), .trn_lnk_up_n_i(trn_lnk_up_n_i),
    .rd_req_i(rd_req), .cpl_done_i(cpl_done), .cfg_to_turnoff_n_i(cfg_to_turnoff_n_i),
    .ep_rst_o(ep_rst), .rx_hold_o(trn_rdst_rdy_n_o),  // Hold is the rx ready
    .cpl_start_o(cpl_start), .cfg_turnoff_ok_n_o(cfg_turnoff_ok_n_o)
  );

  pcie_ep_rx_engine u_rx (
    .trn_clk_i(trn_clk_i), .ep_rst_i(ep_rst), .rx_hold_i(trn_rdst_rdy_n_o),
    .trn_rd_i(trn_rd_i), .trn_rsof_n_i(trn_rsof_n_i), .trn_reof_n_i(trn_reof_n_i),
    .trn_rsrc_rdy_n_i(trn_rsrc_rdy_n_i), .trn_rbar_hit_n_i(trn_rbar_hit_n_i),
    .reg_wr_o(reg_wr), .reg_addr_o(reg_addr), .reg_wdata_o(reg_wdata), .reg_be_o(reg_be),
    .rd_req_o(rd_req), .req_rid_o(req_rid), .req_tag_o(req_tag), .req_tc_o(req_tc),
    .req_attr_o(req_attr), .req_laddr_o(req_laddr)
  );

  // ------------------------------
  // Registers and interrupts
  // ------------------------------
  pcie_ep_regs u_regs (
    .trn_clk_i(trn_clk_i), .ep_rst_i(ep_rst), .reg_wr_i(reg_wr), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_be_i(reg_be), .irq_status_i(irq_status),
    .reg_rdata_o(reg_rdata), .irq_set_o(irq_set), .irq_clr_o(irq_clr)
  );

  pcie_ep_intr_ctrl u_intr (
    .trn_clk_i(trn_clk_i), .ep_rst_i(ep_rst), .irq_set_i(irq_set), .irq_clr_i(irq_clr),
    .cfg_interrupt_rdy_n_i(cfg_interrupt_rdy_n_i),
    .cfg_interrupt_msienable_i(cfg_interrupt_msienable_i), .cfg_command_i(cfg_command_i),
    .irq_status_o(irq_status), .cfg_interrupt_n_o(cfg_interrupt_n_o),
    .cfg_interrupt_assert_n_o(cfg_interrupt_assert_n_o), .cfg_interrupt_di_o(cfg_interrupt_di_o)
  );

  // ------------------------------
  // Completion transmit
  // ------------------------------
  pcie_ep_tx_engine u_tx (
    .trn_clk_i(trn_clk_i), .ep_rst_i(ep_rst), .cpl_start_i(cpl_start),
    .reg_rdata_i(reg_rdata), .req_rid_i(req_rid), .req_tag_i(req_tag), .req_tc_i(req_tc),
    .req_attr_i(req_attr), .req_laddr_i(req_laddr), .cfg_bus_number_i(cfg_bus_number_i),
    .cfg_device_number_i(cfg_device_number_i), .cfg_function_number_i(cfg_function_number_i),
    .trn_tdst_rdy_n_i(trn_tdst_rdy_n_i), .trn_td_o(trn_td_o), .trn_tsof_n_o(trn_tsof_n_o),
    .trn_teof_n_o(trn_teof_n_o), .trn_tsrc_rdy_n_o(trn_tsrc_rdy_n_o), .cpl_done_o(cpl_done)
  );

endmodule

//--- hdl/pcie_ep_tx_engine.sv
// Transmit Local-Link builder
// Sends a two-beat CplD for each cpl_start. Read data and completer id
// are captured at the start, the request fields come held from the rx
// engine. A beat stays on the bus until the core takes it
`timescale 1ns/100ps
`include "pcie_ep_defs.svh"

module pcie_ep_tx_engine (
  input  logic                       trn_clk_i,
  input  logic                       ep_rst_i,
  input  logic                       cpl_start_i,
  input  logic [`PCIE_EP_REG_W-1:0]  reg_rdata_i,
  input  logic [15:0]                req_rid_i,
  input  logic [7:0]                 req_tag_i,
  input  logic [2:0]                 req_tc_i,
  input  logic [1:0]                 req_attr_i,
  input  logic [6:0]                 req_laddr_i,
  input  logic [7:0]                 cfg_bus_number_i,
  input  logic [4:0]                 cfg_device_number_i,
  input  logic [2:0]                 cfg_function_number_i,
  input  logic                       trn_tdst_rdy_n_i,
  output logic [`PCIE_EP_DATA_W-1:0] trn_td_o,
  output logic                       trn_tsof_n_o,
  output logic                       trn_teof_n_o,
  output logic                       trn_tsrc_rdy_n_o,
  output logic                       cpl_done_o
);
  import pcie_ep_pkg::*;

  tx_state_e                 state;
  logic                      taken;
  logic [`PCIE_EP_REG_W-1:0] cpl_data;
  logic [15:0]               cpl_id;     // Bus, device, function
  logic [31:0]               hdr_dw0;
  logic [31:0]               hdr_dw1;
  logic [31:0]               hdr_dw2;

  assign taken = !trn_tsrc_rdy_n_o && !trn_tdst_rdy_n_i;

  // TD, EP and the reserved bits all zero
  assign hdr_dw0 = {1'b0, TLP_CPLD, 1'b0, req_tc_i, 4'b0000, 2'b00, req_attr_i, 2'b00, 10'd1};
  assign hdr_dw1 = {cpl_id, 3'b000, 1'b0, `PCIE_EP_CPL_BYTES}; // Status SC, BCM 0
  assign hdr_dw2 = {req_rid_i, req_tag_i, 1'b0, req_laddr_i};

  assign trn_td_o         = (state == TX_HDR) ? {hdr_dw0, hdr_dw1} : {hdr_dw2, cpl_data};
  assign trn_tsof_n_o     = (state != TX_HDR);
  assign trn_teof_n_o     = (state != TX_DATA);
  assign trn_tsrc_rdy_n_o = (state == TX_IDLE);
  assign cpl_done_o       = taken && state == TX_DATA; // Eof beat taken

  always_ff @(posedge trn_clk_i) begin
    if (ep_rst_i) begin
      state <= TX_IDLE;
    end else begin
      case (state)
        TX_IDLE: begin
          if (cpl_start_i)
            state <= TX_HDR;
        end
        TX_HDR: begin
          if (taken)
            state <= TX_DATA;
        end
        TX_DATA: begin
          if (taken)
            state <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge trn_clk_i) begin
    if (cpl_start_i && state == TX_IDLE) begin
      cpl_data <= reg_rdata_i;
      cpl_id   <= {cfg_bus_number_i, cfg_device_number_i, cfg_function_number_i};
    end
  end

  // Back-pressure holds the beat and its framing
  a_beat_stable: assert property (@(posedge trn_clk_i) disable iff (ep_rst_i)
    (!trn_tsrc_rdy_n_o && trn_tdst_rdy_n_i) |=>
      (!trn_tsrc_rdy_n_o && $stable(trn_td_o) && $stable(trn_tsof_n_o) &&
       $stable(trn_teof_n_o)))
    else $error("tx beat changed before it was taken");

endmodule

//--- pcie_ep_top.f
+incdir+hdl
hdl/pcie_ep_pkg.sv
hdl/pcie_ep_ctrl.sv
hdl/pcie_ep_rx_engine.sv
hdl/pcie_ep_tx_engine.sv
hdl/pcie_ep_regs.sv
hdl/pcie_ep_intr_ctrl.sv
hdl/pcie_ep_top.sv
dv/pcie_ep_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PCIe endpoint testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pcie_ep_top.f --top-module pcie_ep_tb -o pcie_ep_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pcie_ep_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
